// ==== issueTop.f ====
issuePkg.sv
bundleDecode.sv
slotSteer.sv
unitQueue.sv
issueTop.sv
tb_issueTop.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_issueTop
RTL_TOP   ?= issueTop
FILELIST  ?= issueTop.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= issuePkg.sv bundleDecode.sv slotSteer.sv unitQueue.sv issueTop.sv
TB_SRCS   ?= tb_issueTop.sv
PASS_TEXT ?= TEST RESULT: PASS

SIM := $(OBJDIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(RTL_SRCS) $(TB_SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tb_issueTop.sv ====
`timescale 1ns/1ns

module tb_issueTop;

  localparam int NumSlots    = 4;
  localparam int QueueDepth  = 4;
  localparam int IdxWidth    = $clog2(NumSlots);
  localparam int BundleWidth = NumSlots * 32;
  localparam int AcceptLimit = 300;
  localparam int DrainLimit  = 600;

  // class opcode values in bits 7:5
  localparam logic [2:0] TbOpLsu    = 3'd1;
  localparam logic [2:0] TbOpCsr    = 3'd3;
  localparam logic [2:0] TbOpBranch = 3'd4;

  // scoreboard lanes in ready vector bit order
  localparam int ClsAlu  = 0;
  localparam int ClsLsu  = 1;
  localparam int ClsCsr  = 2;
  localparam int ClsMul  = 3;
  localparam int ClsDiv  = 4;
  localparam int ClsNone = 5;

  logic                   w_CsrPmtFire;
  logic                   rstn;
  logic                   i_BundleValid;
  logic                   o_BundleReady;
  logic [BundleWidth-1:0] i_Bundle;
  logic                   i_HasBranch;
  logic [IdxWidth-1:0]    i_BranchIdx;
  logic                   o_LsuValid, o_CsrValid, o_MulValid, o_DivValid, o_AluValid;
  logic [31:0]            o_LsuInst, o_CsrInst, o_MulInst, o_DivInst, o_AluInst;
  logic                   i_LsuReady, i_CsrReady, i_MulReady, i_DivReady, i_AluReady;

  logic [31:0] expQ [5][$];
  integer      seed;
  integer      readySeed;
  int          readyMode;
  logic        mulHold;
  logic [4:0]  readyBits;
  int          errCount;
  int          checkCount;

  issueTop #(.NumSlots(NumSlots), .QueueDepth(QueueDepth)) uut (
    .w_CsrPmtFire (w_CsrPmtFire),
    .rstn         (rstn),
    .i_BundleValid(i_BundleValid),
    .o_BundleReady(o_BundleReady),
    .i_Bundle     (i_Bundle),
    .i_HasBranch  (i_HasBranch),
    .i_BranchIdx  (i_BranchIdx),
    .o_LsuValid   (o_LsuValid),
    .o_LsuInst    (o_LsuInst),
    .i_LsuReady   (i_LsuReady),
    .o_CsrValid   (o_CsrValid),
    .o_CsrInst    (o_CsrInst),
    .i_CsrReady   (i_CsrReady),
    .o_MulValid   (o_MulValid),
    .o_MulInst    (o_MulInst),
    .i_MulReady   (i_MulReady),
    .o_DivValid   (o_DivValid),
    .o_DivInst    (o_DivInst),
    .i_DivReady   (i_DivReady),
    .o_AluValid   (o_AluValid),
    .o_AluInst    (o_AluInst),
    .i_AluReady   (i_AluReady)
  );

  always #50 w_CsrPmtFire = ~w_CsrPmtFire;

  function automatic int classify(input logic [31:0] w);
    logic [2:0] op;
    op = w[7:5];
    if (op == TbOpLsu) return ClsLsu;
    if (op == TbOpCsr) begin
      if (w[11:8] != 4'd0) return ClsMul;
      if (w[15:12] != 4'd0) return ClsDiv;
      return ClsCsr;
    end
    if (op == TbOpBranch) return ClsNone;
    return ClsAlu;
  endfunction

  function automatic logic [31:0] makeWord(input logic [2:0] op, input logic [3:0] mulSel,
                                           input logic [3:0] divSel, input logic [15:0] tag);
    return {tag, divSel, mulSel, op, 5'd0};
  endfunction

  function automatic int pendingCount();
    int total;
    total = 0;
    for (int c = 0; c < 5; c++) total += expQ[c].size();
    return total;
  endfunction

  task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
                            input string what);
    checkCount++;
    if (got !== expected) begin
      $display("Fail at %0t: %s, got %h expected %h", $time, what, got, expected);
      errCount++;
    end
  endtask

  task automatic abortRun(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic queueExpected(input logic [BundleWidth-1:0] b, input logic hb,
                               input logic [IdxWidth-1:0] bi);
    logic [31:0] w;
    int          cls;
    for (int s = 0; s < NumSlots; s++) begin
      w   = b[s*32 +: 32];
      cls = classify(w);
      // live only up to the branch slot when a branch is flagged
      if (cls != ClsNone && (!hb || s <= int'(bi))) expQ[cls].push_back(w);
    end
  endtask

  task automatic offerBundle(input logic [BundleWidth-1:0] b, input logic hb,
                             input logic [IdxWidth-1:0] bi);
    i_Bundle      = b;
    i_HasBranch   = hb;
    i_BranchIdx   = bi;
    i_BundleValid = 1'b1;
  endtask

  task automatic waitAccept(input string what);
    int   cycles;
    logic accepted;
    cycles   = 0;
    accepted = 1'b0;
    while (!accepted && cycles < AcceptLimit) begin
      @(negedge w_CsrPmtFire);
      cycles++;
      accepted = o_BundleReady;
    end
    if (!accepted) begin
      abortRun({"bundle never accepted in ", what});
    end else begin
      queueExpected(i_Bundle, i_HasBranch, i_BranchIdx);
      @(posedge w_CsrPmtFire);
      #5;
      i_BundleValid = 1'b0;
    end
  endtask

  task automatic sendBundle(input logic [BundleWidth-1:0] b, input logic hb,
                            input logic [IdxWidth-1:0] bi, input string what);
    offerBundle(b, hb, bi);
    waitAccept(what);
  endtask

  task automatic waitDrain(input string what);
    int   cycles;
    logic drained;
    cycles  = 0;
    drained = 1'b0;
    while (!drained && cycles < DrainLimit) begin
      @(negedge w_CsrPmtFire);
      cycles++;
      drained = o_BundleReady && (pendingCount() == 0);
    end
    if (!drained) abortRun({"queues did not drain in ", what});
  endtask

  task automatic alignDrive();
    @(posedge w_CsrPmtFire);
    #5;
  endtask

  task automatic makeRandomBundle(output logic [BundleWidth-1:0] b, output logic hb,
                                  output logic [IdxWidth-1:0] bi);
    logic [31:0] w;
    logic [31:0] r;
    for (int s = 0; s < NumSlots; s++) begin
      w = $random(seed);
      r = $random(seed);
      // lean towards the csr opcode so mul, div and csr all occur
      if (r[0]) w[7:5] = TbOpCsr;
      if (r[1]) w[11:8] = 4'd0;
      if (r[2]) w[15:12] = 4'd0;
      b[s*32 +: 32] = w;
    end
    r  = $random(seed);
    hb = r[8];
    bi = r[IdxWidth+3:4];
  endtask

  task automatic popCheck(input int cls, input logic valid, input logic ready,
                          input logic [31:0] inst, input string name);
    logic [31:0] expected;
    if (valid && ready) begin
      if (expQ[cls].size() == 0) begin
        $display("unexpected word %h on the %s output at %0t", inst, name, $time);
        errCount++;
      end else begin
        expected = expQ[cls].pop_front();
        checkValue(inst, expected, {name, " output word"});
      end
    end
  endtask

  task automatic endTest(input int num, input string name, input int errBefore);
    $display("test %0d %s done, %0d errors", num, name, errCount - errBefore);
  endtask

  // sampled on the falling edge before the pop at the next rise
  always @(negedge w_CsrPmtFire) begin
    if (rstn) begin
      popCheck(ClsAlu, o_AluValid, i_AluReady, o_AluInst, "alu");
      popCheck(ClsLsu, o_LsuValid, i_LsuReady, o_LsuInst, "lsu");
      popCheck(ClsCsr, o_CsrValid, i_CsrReady, o_CsrInst, "csr");
      popCheck(ClsMul, o_MulValid, i_MulReady, o_MulInst, "mul");
      popCheck(ClsDiv, o_DivValid, i_DivReady, o_DivInst, "div");
    end
  end

  always @(posedge w_CsrPmtFire) begin
    #5;
    readyBits = (readyMode == 1) ? 5'($random(readySeed)) : 5'h1f;
    if (mulHold) readyBits[ClsMul] = 1'b0;
    {i_DivReady, i_MulReady, i_CsrReady, i_LsuReady, i_AluReady} = readyBits;
  end

  initial begin
    int                     errBefore;
    int                     readyHighs;
    logic [BundleWidth-1:0] bundle;
    logic                   hasBr;
    logic [IdxWidth-1:0]    brIdx;
    seed          = 24718;
    readySeed     = 24718;
    readyMode     = 0;
    mulHold       = 1'b0;
    errCount      = 0;
    checkCount    = 0;
    w_CsrPmtFire  = 1'b0;
    rstn          = 1'b0;
    i_BundleValid = 1'b0;
    i_Bundle      = '0;
    i_HasBranch   = 1'b0;
    i_BranchIdx   = '0;
    {i_DivReady, i_MulReady, i_CsrReady, i_LsuReady, i_AluReady} = 5'h1f;
    repeat (5) @(posedge w_CsrPmtFire);
    #5;
    rstn = 1'b1;

    errBefore = errCount;
    @(negedge w_CsrPmtFire);
    checkValue(32'({o_AluValid, o_LsuValid, o_CsrValid, o_MulValid, o_DivValid}), 32'd0,
               "class valids after reset");
    checkValue(32'(o_BundleReady), 32'd1, "bundle ready after reset");
    endTest(1, "reset state", errBefore);

    errBefore = errCount;
    alignDrive();
    sendBundle({makeWord(TbOpCsr, 4'h0, 4'h0, 16'h0013), makeWord(TbOpBranch, 4'h0, 4'h0, 16'h0012),
                makeWord(TbOpLsu, 4'h0, 4'h0, 16'h0011), makeWord(3'd2, 4'h5, 4'h0, 16'h0010)},
               1'b0, '0, "directed classes");
    sendBundle({makeWord(TbOpLsu, 4'h0, 4'h0, 16'h0023), makeWord(3'd0, 4'h0, 4'h0, 16'h0022),
                makeWord(TbOpCsr, 4'h0, 4'h2, 16'h0021), makeWord(TbOpCsr, 4'h1, 4'h3, 16'h0020)},
               1'b0, '0, "directed classes");
    waitDrain("directed classes");
    endTest(2, "directed classes", errBefore);

    errBefore = errCount;
    alignDrive();
    sendBundle({makeWord(TbOpCsr, 4'h4, 4'h0, 16'h0033), makeWord(TbOpCsr, 4'h0, 4'h0, 16'h0032),
                makeWord(TbOpLsu, 4'h0, 4'h0, 16'h0031), makeWord(3'd0, 4'h0, 4'h0, 16'h0030)},
               1'b1, 2'd1, "branch cut-off");
    sendBundle({makeWord(3'd7, 4'h0, 4'h0, 16'h0037), makeWord(TbOpBranch, 4'h0, 4'h0, 16'h0036),
                makeWord(TbOpCsr, 4'h0, 4'h1, 16'h0035), makeWord(TbOpLsu, 4'h0, 4'h0, 16'h0034)},
               1'b1, 2'd2, "branch cut-off");
    sendBundle({makeWord(TbOpLsu, 4'h0, 4'h0, 16'h003b), makeWord(3'd0, 4'h0, 4'h0, 16'h003a),
                makeWord(3'd5, 4'h0, 4'h0, 16'h0039), makeWord(TbOpCsr, 4'h2, 4'h0, 16'h0038)},
               1'b1, 2'd0, "branch cut-off");
    waitDrain("branch cut-off");
    endTest(3, "branch cut-off", errBefore);

    errBefore = errCount;
    mulHold   = 1'b1;
    alignDrive();
    sendBundle({makeWord(TbOpCsr, 4'h3, 4'h0, 16'h0043), makeWord(TbOpCsr, 4'h3, 4'h0, 16'h0042),
                makeWord(TbOpCsr, 4'h3, 4'h0, 16'h0041), makeWord(TbOpCsr, 4'h3, 4'h0, 16'h0040)},
               1'b0, '0, "mul back-pressure");
    sendBundle({makeWord(TbOpLsu, 4'h0, 4'h0, 16'h0047), makeWord(TbOpCsr, 4'h6, 4'h0, 16'h0046),
                makeWord(3'd0, 4'h0, 4'h0, 16'h0045), makeWord(TbOpCsr, 4'h7, 4'h0, 16'h0044)},
               1'b0, '0, "mul back-pressure");
    offerBundle({makeWord(TbOpCsr, 4'h8, 4'h0, 16'h004b), makeWord(TbOpCsr, 4'h0, 4'h0, 16'h004a),
                 makeWord(TbOpCsr, 4'h9, 4'h0, 16'h0049), makeWord(TbOpCsr, 4'ha, 4'h0, 16'h0048)},
                1'b0, '0);
    readyHighs = 0;
    for (int c = 0; c < 20; c++) begin
      @(negedge w_CsrPmtFire);
      if (o_BundleReady) readyHighs++;
    end
    checkValue(32'(readyHighs), 32'd0, "bundle ready cycles while mul queue stalled");
    mulHold = 1'b0;
    waitAccept("mul back-pressure");
    waitDrain("mul back-pressure");
    endTest(4, "mul back-pressure", errBefore);

    errBefore = errCount;
    readyMode = 1;
    alignDrive();
    for (int n = 0; n < 200; n++) begin
      makeRandomBundle(bundle, hasBr, brIdx);
      sendBundle(bundle, hasBr, brIdx, "random run");
    end
    waitDrain("random run");
    readyMode = 0;
    repeat (5) @(negedge w_CsrPmtFire);
    checkValue(32'({o_AluValid, o_LsuValid, o_CsrValid, o_MulValid, o_DivValid}), 32'd0,
               "class valids after random run");
    endTest(5, "random run", errBefore);

    $display("checks %0d, errors %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== issueTop.sv ====
`timescale 1ns/1ns

module issueTop #(
  parameter int NumSlots   = 4,
  parameter int QueueDepth = 4
) (
  input  logic                                    w_CsrPmtFire,
  input  logic                                    rstn,
  input  logic                                    i_BundleValid,
  output logic                                    o_BundleReady,
  input  logic [NumSlots*issuePkg::InstWidth-1:0] i_Bundle,
  input  logic                                    i_HasBranch,
  input  logic [$clog2(NumSlots)-1:0]             i_BranchIdx,
  output logic                                    o_LsuValid,
  output logic [issuePkg::InstWidth-1:0]          o_LsuInst,
  input  logic                                    i_LsuReady,
  output logic                                    o_CsrValid,
  output logic [issuePkg::InstWidth-1:0]          o_CsrInst,
  input  logic                                    i_CsrReady,
  output logic                                    o_MulValid,
  output logic [issuePkg::InstWidth-1:0]          o_MulInst,
  input  logic                                    i_MulReady,
  output logic                                    o_DivValid,
  output logic [issuePkg::InstWidth-1:0]          o_DivInst,
  input  logic                                    i_DivReady,
  output logic                                    o_AluValid,
  output logic [issuePkg::InstWidth-1:0]          o_AluInst,
  input  logic                                    i_AluReady
);

  import issuePkg::*;

  logic [NumSlots-1:0]           w_SlotValid;
  unitSel_e                      w_SlotClass [NumSlots];
  logic [NumSlots*InstWidth-1:0] w_SlotInst;
  logic                          w_SlotsDone;
  logic [NumUnits-1:0]           w_PushValid;
  logic [InstWidth-1:0]          w_PushInst;
  logic [NumUnits-1:0]           w_PushReady;

  bundleDecode #(.NumSlots(NumSlots)) decode (
    .w_CsrPmtFire (w_CsrPmtFire),
    .rstn         (rstn),
    .i_BundleValid(i_BundleValid),
    .o_BundleReady(o_BundleReady),
    .i_Bundle     (i_Bundle),
    .i_HasBranch  (i_HasBranch),
    .i_BranchIdx  (i_BranchIdx),
    .i_SlotsDone  (w_SlotsDone),
    .o_SlotValid  (w_SlotValid),
    .o_SlotClass  (w_SlotClass),
    .o_SlotInst   (w_SlotInst)
  );

  slotSteer #(.NumSlots(NumSlots)) steer (
    .w_CsrPmtFire(w_CsrPmtFire),
    .rstn        (rstn),
    .i_SlotValid (w_SlotValid),
    .i_SlotClass (w_SlotClass),
    .i_SlotInst  (w_SlotInst),
    .o_SlotsDone (w_SlotsDone),
    .o_PushValid (w_PushValid),
    .o_PushInst  (w_PushInst),
    .i_PushReady (w_PushReady)
  );

  // one queue per class, push lanes indexed by class
  unitQueue #(.QueueDepth(QueueDepth)) lsuQueue (
    .w_CsrPmtFire(w_CsrPmtFire),
    .rstn        (rstn),
    .i_PushValid (w_PushValid[UnitLsu]),
    .o_PushReady (w_PushReady[UnitLsu]),
    .i_PushInst  (w_PushInst),
    .o_PopValid  (o_LsuValid),
    .i_PopReady  (i_LsuReady),
    .o_PopInst   (o_LsuInst)
  );

  unitQueue #(.QueueDepth(QueueDepth)) csrQueue (
    .w_CsrPmtFire(w_CsrPmtFire),
    .rstn        (rstn),
    .i_PushValid (w_PushValid[UnitCsr]),
    .o_PushReady (w_PushReady[UnitCsr]),
    .i_PushInst  (w_PushInst),
    .o_PopValid  (o_CsrValid),
    .i_PopReady  (i_CsrReady),
    .o_PopInst   (o_CsrInst)
  );

  unitQueue #(.QueueDepth(QueueDepth)) mulQueue (
    .w_CsrPmtFire(w_CsrPmtFire),
    .rstn        (rstn),
    .i_PushValid (w_PushValid[UnitMul]),
    .o_PushReady (w_PushReady[UnitMul]),
    .i_PushInst  (w_PushInst),
    .o_PopValid  (o_MulValid),
    .i_PopReady  (i_MulReady),
    .o_PopInst   (o_MulInst)
  );

  unitQueue #(.QueueDepth(QueueDepth)) divQueue (
    .w_CsrPmtFire(w_CsrPmtFire),
    .rstn        (rstn),
    .i_PushValid (w_PushValid[UnitDiv]),
    .o_PushReady (w_PushReady[UnitDiv]),
    .i_PushInst  (w_PushInst),
    .o_PopValid  (o_DivValid),
    .i_PopReady  (i_DivReady),
    .o_PopInst   (o_DivInst)
  );

  unitQueue #(.QueueDepth(QueueDepth)) aluQueue (
    .w_CsrPmtFire(w_CsrPmtFire),
    .rstn        (rstn),
    .i_PushValid (w_PushValid[UnitAlu]),
    .o_PushReady (w_PushReady[UnitAlu]),
    .i_PushInst  (w_PushInst),
    .o_PopValid  (o_AluValid),
    .i_PopReady  (i_AluReady),
    .o_PopInst   (o_AluInst)
  );

endmodule

// ==== unitQueue.sv ====
`timescale 1ns/1ns

module unitQueue #(
  parameter int QueueDepth = 4
) (
  input  logic                           w_CsrPmtFire,
  input  logic                           rstn,
  input  logic                           i_PushValid,
  output logic                           o_PushReady,
  input  logic [issuePkg::InstWidth-1:0] i_PushInst,
  output logic                           o_PopValid,
  input  logic                           i_PopReady,
  output logic [issuePkg::InstWidth-1:0] o_PopInst
);

  import issuePkg::*;

  localparam int PtrWidth   = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int CountWidth = $clog2(QueueDepth + 1);

  logic [InstWidth-1:0]  r_Mem [QueueDepth];
  logic [PtrWidth-1:0]   r_WrPtr;
  logic [PtrWidth-1:0]   r_RdPtr;
  logic [CountWidth-1:0] r_Count;
  logic                  w_Full;
  logic                  w_Push;
  logic                  w_Pop;

  function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(QueueDepth - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  assign w_Full      = (r_Count == CountWidth'(QueueDepth));
  assign o_PopValid  = (r_Count != '0);
  // a pop frees the slot in the same cycle
  assign o_PushReady = !w_Full || i_PopReady;
  assign w_Push      = i_PushValid && o_PushReady;
  assign w_Pop       = o_PopValid && i_PopReady;
  assign o_PopInst   = r_Mem[r_RdPtr];

  always_ff @(posedge w_CsrPmtFire or negedge rstn) begin
    if (!rstn) begin
      r_WrPtr <= '0;
      r_RdPtr <= '0;
      r_Count <= '0;
    end else begin
      if (w_Push) begin
        r_WrPtr <= nextPtr(r_WrPtr);
      end
      if (w_Pop) begin
        r_RdPtr <= nextPtr(r_RdPtr);
      end
      if (w_Push && !w_Pop) begin
        r_Count <= r_Count + 1'b1;
      end else if (w_Pop && !w_Push) begin
        r_Count <= r_Count - 1'b1;
      end
    end
  end

  always_ff @(posedge w_CsrPmtFire) begin
    if (w_Push) begin
      r_Mem[r_WrPtr] <= i_PushInst;
    end
  end

endmodule

// ==== slotSteer.sv ====
`timescale 1ns/1ns

module slotSteer #(
  parameter int NumSlots = 4
) (
  input  logic                                    w_CsrPmtFire,
  input  logic                                    rstn,
  input  logic [NumSlots-1:0]                     i_SlotValid,
  input  issuePkg::unitSel_e                      i_SlotClass [NumSlots],
  input  logic [NumSlots*issuePkg::InstWidth-1:0] i_SlotInst,
  output logic                                    o_SlotsDone,
  output logic [issuePkg::NumUnits-1:0]           o_PushValid,
  output logic [issuePkg::InstWidth-1:0]          o_PushInst,
  input  logic [issuePkg::NumUnits-1:0]           i_PushReady
);

  import issuePkg::*;

  localparam int SelWidth = $clog2(NumSlots);

  logic [NumSlots-1:0] r_Consumed;
  logic [NumSlots-1:0] w_Remaining;
  logic                w_Found;
  logic [SelWidth-1:0] w_Sel;
  unitSel_e            w_SelClass;
  logic                w_PushFire;

  assign w_Remaining = i_SlotValid & ~r_Consumed;

  // lowest live slot not yet pushed
  always_comb begin
    w_Found = 1'b0;
    w_Sel   = '0;
    for (int s = 0; s < NumSlots; s++) begin
      if (w_Remaining[s] && !w_Found) begin
        w_Found = 1'b1;
        w_Sel   = SelWidth'(s);
      end
    end
  end

  assign w_SelClass = i_SlotClass[w_Sel];
  assign o_PushInst = i_SlotInst[w_Sel*InstWidth +: InstWidth];

  // only the queue of the selected class sees valid
  always_comb begin
    for (int u = 0; u < NumUnits; u++) begin
      o_PushValid[u] = w_Found && (w_SelClass == unitSel_e'(u));
    end
  end

  assign w_PushFire = |(o_PushValid & i_PushReady);

  // high once nothing is left, also while no bundle is held
  assign o_SlotsDone = ~|w_Remaining;

  always_ff @(posedge w_CsrPmtFire or negedge rstn) begin
    if (!rstn) begin
      r_Consumed <= '0;
    end else if (o_SlotsDone) begin
      r_Consumed <= '0;
    end else if (w_PushFire) begin
      r_Consumed[w_Sel] <= 1'b1;
    end
  end

endmodule

// ==== bundleDecode.sv ====
`timescale 1ns/1ns

module bundleDecode #(
  parameter int NumSlots = 4
) (
  input  logic                                        w_CsrPmtFire,
  input  logic                                        rstn,
  input  logic                                        i_BundleValid,
  output logic                                        o_BundleReady,
  input  logic [NumSlots*issuePkg::InstWidth-1:0]     i_Bundle,
  input  logic                                        i_HasBranch,
  input  logic [$clog2(NumSlots)-1:0]                 i_BranchIdx,
  input  logic                                        i_SlotsDone,
  output logic [NumSlots-1:0]                         o_SlotValid,
  output issuePkg::unitSel_e                          o_SlotClass [NumSlots],
  output logic [NumSlots*issuePkg::InstWidth-1:0]     o_SlotInst
);

  import issuePkg::*;

  logic                          r_Ready;
  logic [NumSlots-1:0]           r_Live;
  logic [NumSlots-1:0]           w_Live;
  logic [NumSlots*InstWidth-1:0] r_SlotInst;
  unitSel_e                      r_SlotClass [NumSlots];
  unitSel_e                      w_Class [NumSlots];
  logic                          w_Accept;

  function automatic unitSel_e classify(input logic [InstWidth-1:0] inst);
    logic [OpcodeMsb-OpcodeLsb:0] opcode;
    opcode = inst[OpcodeMsb:OpcodeLsb];
    case (opcode)
      OpLsu: return UnitLsu;
      OpCsrMulDiv: begin
        // mul select wins over div select
        if (|inst[MulSelMsb:MulSelLsb]) return UnitMul;
        if (|inst[DivSelMsb:DivSelLsb]) return UnitDiv;
        return UnitCsr;
      end
      OpBranch: return UnitNone;
      default: return UnitAlu;
    endcase
  endfunction

  assign w_Accept = i_BundleValid && r_Ready;

  always_comb begin
    for (int s = 0; s < NumSlots; s++) begin
      w_Class[s] = classify(i_Bundle[s*InstWidth +: InstWidth]);
      // cut off everything past the branch slot
      w_Live[s] = (w_Class[s] != UnitNone) && (!i_HasBranch || s <= int'(i_BranchIdx));
    end
  end

  // accept has priority, done is also seen while idle
  always_ff @(posedge w_CsrPmtFire or negedge rstn) begin
    if (!rstn) begin
      r_Ready <= 1'b1;
      r_Live  <= '0;
    end else if (w_Accept) begin
      r_Ready <= 1'b0;
      r_Live  <= w_Live;
    end else if (i_SlotsDone) begin
      r_Ready <= 1'b1;
      r_Live  <= '0;
    end
  end

  always_ff @(posedge w_CsrPmtFire) begin
    if (w_Accept) begin
      r_SlotInst  <= i_Bundle;
      r_SlotClass <= w_Class;
    end
  end

  assign o_BundleReady = r_Ready;
  assign o_SlotValid   = r_Live;
  assign o_SlotClass   = r_SlotClass;
  assign o_SlotInst    = r_SlotInst;

endmodule

// ==== issuePkg.sv ====
package issuePkg;

  localparam int InstWidth = 32;

  // class opcode field
  localparam int OpcodeLsb = 5;
  localparam int OpcodeMsb = 7;

  // nonzero select fields split the csr opcode into mul and div
  localparam int MulSelLsb = 8;
  localparam int MulSelMsb = 11;
  localparam int DivSelLsb = 12;
  localparam int DivSelMsb = 15;

  localparam logic [2:0] OpLsu       = 3'd1;
  localparam logic [2:0] OpCsrMulDiv = 3'd3;
  localparam logic [2:0] OpBranch    = 3'd4;

  // one issue queue per real class
  localparam int NumUnits = 5;

  // values below NumUnits double as queue index
  typedef enum logic [2:0] {
    UnitAlu  = 3'd0,
    UnitLsu  = 3'd1,
    UnitCsr  = 3'd2,
    UnitMul  = 3'd3,
    UnitDiv  = 3'd4,
    UnitNone = 3'd5
  } unitSel_e;

endpackage
